// ==== verilog.f ====
hw/adma_pkg.sv
hw/adma_sequencer.sv
hw/axi_read_engine.sv
hw/axi_write_engine.sv
hw/sd_adma_top.sv
test/sd_adma_props.sv
test/sd_adma_tb.sv

// ==== test/sd_adma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_adma_tb;

  localparam int unsigned burst_beats    = 16;
  localparam int unsigned mem_words      = 16384;
  localparam logic [15:0] lfsr_seed      = 16'd17651;
  // Five short chains of at most about a thousand cycles each
  localparam int unsigned timeout_cycles = 20000;

  logic               clock;
  logic               reset;
  logic               dma_enable;
  logic               cmd_done;
  logic               data_present;
  logic               dir_write;
  logic               blk_gap_req;
  logic               irq_clear;
  adma_pkg::addr_t    desc_ptr_init;
  logic               irq_complete;
  logic               irq_error;
  adma_pkg::word_t    card_wdata;
  logic               card_wvalid;
  logic               card_push;
  adma_pkg::word_t    card_rdata;
  logic               card_pop;
  adma_pkg::addr_t    ar_addr;
  adma_pkg::beats_t   ar_len;
  logic [2:0]         ar_size;
  logic [1:0]         ar_burst;
  logic               ar_valid;
  logic               ar_ready;
  adma_pkg::word_t    r_data;
  logic               r_valid;
  logic               r_last;
  logic               r_ready;
  adma_pkg::addr_t    aw_addr;
  adma_pkg::beats_t   aw_len;
  logic [2:0]         aw_size;
  logic [1:0]         aw_burst;
  logic               aw_valid;
  logic               aw_ready;
  adma_pkg::word_t    w_data;
  logic               w_valid;
  logic               w_last;
  logic               w_ready;

  // System memory and what the monitor saw on the buses
  adma_pkg::word_t    mem [0:mem_words-1];
  adma_pkg::word_t    card_rx [$];
  adma_pkg::word_t    card_q [$];
  adma_pkg::addr_t    ar_addrs [$];
  adma_pkg::beats_t   ar_lens [$];
  adma_pkg::addr_t    aw_addrs [$];
  adma_pkg::beats_t   aw_lens [$];
  logic               w_lasts [$];
  adma_pkg::addr_t    wr_ptr;
  int unsigned        card_reads = 0;
  int unsigned        feed_target = 0;

  sd_adma_top #(
    .burst_beats (burst_beats)
  ) u_sd_adma_top (.*);

  initial begin : clock_gen
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned mem_index(input adma_pkg::addr_t a);
    return int'(a[15:2]);
  endfunction

  // Rotated address so every word differs
  function automatic adma_pkg::word_t fill_word(input adma_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic adma_pkg::word_t card_word(input int unsigned i);
    return 32'hca5d_0000 | adma_pkg::word_t'(i[15:0]);
  endfunction

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  // Two bits per delay give 0 to 3 cycles
  task automatic draw_delay(inout logic [15:0] state, output int unsigned cycles);
    cycles = 0;
    repeat (2) begin
      cycles = cycles * 2 + state[0];
      state  = lfsr_step(state);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic put_desc(input adma_pkg::addr_t at, input logic valid, input logic last,
                          input logic [1:0] act, input logic [15:0] len,
                          input adma_pkg::addr_t target);
    mem[mem_index(at)]     = {len, 10'd0, act, 2'd0, last, valid};
    mem[mem_index(at) + 1] = target;
  endtask

  // Start a chain and wait for either interrupt
  task automatic run_chain(input adma_pkg::addr_t first, input logic to_memory);
    card_rx.delete();
    ar_addrs.delete();
    ar_lens.delete();
    aw_addrs.delete();
    aw_lens.delete();
    w_lasts.delete();
    desc_ptr_init = first;
    dir_write     = to_memory;
    cmd_done      = 1'b1;
    @(negedge clock);
    cmd_done = 1'b0;
    while (!(irq_complete || irq_error)) begin
      @(negedge clock);
    end
  endtask

  task automatic clear_irq();
    irq_clear = 1'b1;
    @(negedge clock);
    irq_clear = 1'b0;
    expect_eq("irq_complete", 0, irq_complete);
    expect_eq("irq_error", 0, irq_error);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder and card FIFO model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : read_responder
    logic [15:0]     lfsr;
    adma_pkg::addr_t addr;
    int unsigned     len;
    int unsigned     stall;
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r_last   = 1'b0;
    r_data   = '0;
    lfsr     = lfsr_seed;
    forever begin
      @(negedge clock);
      if (ar_valid === 1'b1) begin
        draw_delay(lfsr, stall);
        repeat (stall) @(negedge clock);
        ar_ready = 1'b1;
        addr     = ar_addr;
        len      = ar_len;
        @(negedge clock);
        ar_ready = 1'b0;
        for (int unsigned i = 0; i <= len; i++) begin
          draw_delay(lfsr, stall);
          r_valid = 1'b0;
          repeat (stall) @(negedge clock);
          r_valid = 1'b1;
          r_data  = mem[mem_index(addr)];
          r_last  = (i == len);
          while (r_ready !== 1'b1) begin
            @(negedge clock);
          end
          @(negedge clock);
          addr = addr + 4;
        end
        r_valid = 1'b0;
        r_last  = 1'b0;
      end
    end
  end

  initial begin : write_responder
    logic [15:0] lfsr;
    int unsigned len;
    int unsigned stall;
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    lfsr     = lfsr_seed;
    forever begin
      @(negedge clock);
      if (aw_valid === 1'b1) begin
        draw_delay(lfsr, stall);
        repeat (stall) @(negedge clock);
        aw_ready = 1'b1;
        len      = aw_len;
        @(negedge clock);
        aw_ready = 1'b0;
        for (int unsigned i = 0; i <= len; i++) begin
          draw_delay(lfsr, stall);
          w_ready = 1'b0;
          repeat (stall) @(negedge clock);
          w_ready = 1'b1;
          while (w_valid !== 1'b1) begin
            @(negedge clock);
          end
          @(negedge clock);
        end
        w_ready = 1'b0;
      end
    end
  end

  // One push per cycle while words are owed and pops that follow card_pop
  initial begin : card_model
    int unsigned sent;
    int unsigned popped;
    sent       = 0;
    popped     = 0;
    card_push  = 1'b0;
    card_rdata = '0;
    forever begin
      @(negedge clock);
      while (popped < card_reads) begin
        void'(card_q.pop_front());
        popped++;
      end
      card_push = 1'b0;
      if (sent < feed_target) begin
        card_push = 1'b1;
        card_q.push_back(card_word(sent));
        sent++;
      end
      card_rdata = (card_q.size() != 0) ? card_q[0] : '0;
    end
  end

  always @(posedge clock) begin : bus_monitor
    if (card_wvalid === 1'b1) begin
      card_rx.push_back(card_wdata);
    end
    if (card_pop === 1'b1) begin
      card_reads++;
    end
    if (ar_valid === 1'b1 && ar_ready === 1'b1) begin
      ar_addrs.push_back(ar_addr);
      ar_lens.push_back(ar_len);
    end
    if (aw_valid === 1'b1 && aw_ready === 1'b1) begin
      wr_ptr = aw_addr;
      aw_addrs.push_back(aw_addr);
      aw_lens.push_back(aw_len);
    end
    if (w_valid === 1'b1 && w_ready === 1'b1) begin
      mem[mem_index(wr_ptr)] = w_data;
      w_lasts.push_back(w_last);
      wr_ptr = wr_ptr + 4;
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles >= timeout_cycles) begin
        abort_run("timeout, no interrupt arrived within the cycle limit");
      end
      if (u_sd_adma_top.u_props.violations != 0) begin
        abort_run("a bus protocol property failed");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    reset         = 1'b0;
    dma_enable    = 1'b0;
    cmd_done      = 1'b0;
    data_present  = 1'b0;
    dir_write     = 1'b0;
    blk_gap_req   = 1'b0;
    irq_clear     = 1'b0;
    desc_ptr_init = '0;
    for (int unsigned i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(adma_pkg::addr_t'(i * 4));
    end
    repeat (10) @(negedge clock);
    reset        = 1'b1;
    dma_enable   = 1'b1;
    data_present = 1'b1;
    @(negedge clock);
    expect_eq("ar_size", 3'b010, ar_size);
    expect_eq("ar_burst", 2'b01, ar_burst);
    expect_eq("aw_size", 3'b010, aw_size);
    expect_eq("aw_burst", 2'b01, aw_burst);

    // Memory to card with 40 words in bursts of 16, 16 and 8
    put_desc(32'h0100, 1'b1, 1'b1, 2'b10, 16'd160, 32'h2000);
    run_chain(32'h0100, 1'b0);
    expect_eq("irq_complete", 1, irq_complete);
    expect_eq("irq_error", 0, irq_error);
    expect_eq("card_wvalid count", 40, card_rx.size());
    for (int unsigned i = 0; i < 40; i++) begin
      expect_eq("card_wdata", fill_word(32'h2000 + 4 * i), card_rx[i]);
    end
    expect_eq("ar handshakes", 4, ar_lens.size());
    for (int unsigned b = 0; b < 3; b++) begin
      expect_eq("ar_addr", 32'h2000 + 64 * b, ar_addrs[b + 1]);
      expect_eq("ar_len", (b == 2) ? 7 : 15, ar_lens[b + 1]);
    end
    clear_irq();

    // Card to memory
    put_desc(32'h0200, 1'b1, 1'b1, 2'b10, 16'd160, 32'h4000);
    feed_target = 40;
    run_chain(32'h0200, 1'b1);
    expect_eq("irq_complete", 1, irq_complete);
    expect_eq("irq_error", 0, irq_error);
    expect_eq("card_pop count", 40, card_reads);
    expect_eq("w beats", 40, w_lasts.size());
    for (int unsigned i = 0; i < 40; i++) begin
      expect_eq("w_last", ((i % 16) == 15) || (i == 39), w_lasts[i]);
      expect_eq("memory word", card_word(i), mem[mem_index(32'h4000 + 4 * i)]);
    end
    expect_eq("aw handshakes", 3, aw_lens.size());
    for (int unsigned b = 0; b < 3; b++) begin
      expect_eq("aw_addr", 32'h4000 + 64 * b, aw_addrs[b]);
      expect_eq("aw_len", (b == 2) ? 7 : 15, aw_lens[b]);
    end
    clear_irq();

    // Link and then Nop with end
    put_desc(32'h0300, 1'b1, 1'b0, 2'b11, 16'd0, 32'h0800);
    put_desc(32'h0800, 1'b1, 1'b1, 2'b00, 16'd0, 32'h0000);
    run_chain(32'h0300, 1'b0);
    expect_eq("irq_complete", 1, irq_complete);
    expect_eq("irq_error", 0, irq_error);
    expect_eq("descriptor fetches", 2, ar_addrs.size());
    expect_eq("ar_addr", 32'h0300, ar_addrs[0]);
    expect_eq("ar_addr", 32'h0800, ar_addrs[1]);
    clear_irq();

    // Invalid descriptor moves no data
    put_desc(32'h0400, 1'b0, 1'b0, 2'b10, 16'd64, 32'h2000);
    run_chain(32'h0400, 1'b0);
    expect_eq("irq_error", 1, irq_error);
    expect_eq("irq_complete", 0, irq_complete);
    repeat (20) @(negedge clock);
    expect_eq("ar handshakes", 1, ar_addrs.size());
    expect_eq("card_wvalid count", 0, card_rx.size());
    expect_eq("aw handshakes", 0, aw_lens.size());
    clear_irq();

    // Block gap after a non-end Tran leaves the next descriptor unread
    put_desc(32'h0500, 1'b1, 1'b0, 2'b10, 16'd32, 32'h6000);
    put_desc(32'h0508, 1'b1, 1'b1, 2'b10, 16'd16, 32'h6100);
    blk_gap_req = 1'b1;
    run_chain(32'h0500, 1'b0);
    expect_eq("irq_complete", 1, irq_complete);
    expect_eq("irq_error", 0, irq_error);
    repeat (30) @(negedge clock);
    expect_eq("ar handshakes", 2, ar_addrs.size());
    expect_eq("ar_addr", 32'h6000, ar_addrs[1]);
    expect_eq("card_wvalid count", 8, card_rx.size());
    for (int unsigned i = 0; i < 8; i++) begin
      expect_eq("card_wdata", fill_word(32'h6000 + 4 * i), card_rx[i]);
    end
    blk_gap_req = 1'b0;
    clear_irq();

    if (u_sd_adma_top.u_props.violations == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("a bus protocol property failed");
    end
  end

endmodule

`default_nettype wire

// ==== test/sd_adma_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_adma_props #(
  parameter int unsigned burst_beats = 16
) (
  input logic               clock,
  input logic               reset,
  input adma_pkg::addr_t    ar_addr,
  input adma_pkg::beats_t   ar_len,
  input logic               ar_valid,
  input logic               ar_ready,
  input adma_pkg::addr_t    aw_addr,
  input adma_pkg::beats_t   aw_len,
  input logic               aw_valid,
  input logic               aw_ready,
  input adma_pkg::word_t    w_data,
  input logic               w_valid,
  input logic               w_last,
  input logic               w_ready,
  input logic               irq_complete,
  input logic               irq_error
);

  // Read by the testbench watchdog
  int unsigned violations = 0;

  ////////////////////////////////////////////////////////////////////////////
  // AXI request and data hold under back-pressure
  ////////////////////////////////////////////////////////////////////////////

  ar_hold: assert property (@(posedge clock) disable iff (!reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
    else begin
      $error("AR request dropped or changed before ar_ready");
      violations++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (!reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len))
    else begin
      $error("AW request dropped or changed before aw_ready");
      violations++;
    end

  w_hold: assert property (@(posedge clock) disable iff (!reset)
    w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
    else begin
      $error("W beat dropped or changed before w_ready");
      violations++;
    end

  w_last_on_beat: assert property (@(posedge clock) disable iff (!reset)
    w_last |-> w_valid)
    else begin
      $error("w_last without w_valid");
      violations++;
    end

  // Burst length limits
  ar_len_max: assert property (@(posedge clock) disable iff (!reset)
    ar_len <= adma_pkg::beats_t'(burst_beats - 1))
    else begin
      $error("ar_len above the burst limit");
      violations++;
    end

  aw_len_max: assert property (@(posedge clock) disable iff (!reset)
    aw_len <= adma_pkg::beats_t'(burst_beats - 1))
    else begin
      $error("aw_len above the burst limit");
      violations++;
    end

  irq_exclusive: assert property (@(posedge clock) disable iff (!reset)
    !($rose(irq_complete) && $rose(irq_error)))
    else begin
      $error("complete and error interrupts rose together");
      violations++;
    end

endmodule

bind sd_adma_top sd_adma_props #(
  .burst_beats (burst_beats)
) u_props (
  .clock        (clock),
  .reset        (reset),
  .ar_addr      (ar_addr),
  .ar_len       (ar_len),
  .ar_valid     (ar_valid),
  .ar_ready     (ar_ready),
  .aw_addr      (aw_addr),
  .aw_len       (aw_len),
  .aw_valid     (aw_valid),
  .aw_ready     (aw_ready),
  .w_data       (w_data),
  .w_valid      (w_valid),
  .w_last       (w_last),
  .w_ready      (w_ready),
  .irq_complete (irq_complete),
  .irq_error    (irq_error)
);

`default_nettype wire

// ==== hw/sd_adma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_adma_top #(
  parameter int unsigned burst_beats = 16
) (
  input  logic              clock,
  input  logic              reset,
  // Host controller side
  input  logic              dma_enable,
  input  logic              cmd_done,
  input  logic              data_present,
  input  logic              dir_write,
  input  logic              blk_gap_req,
  input  logic              irq_clear,
  input  adma_pkg::addr_t   desc_ptr_init,
  output logic              irq_complete,
  output logic              irq_error,
  // Card data FIFO
  output adma_pkg::word_t   card_wdata,
  output logic              card_wvalid,
  input  logic              card_push,
  input  adma_pkg::word_t   card_rdata,
  output logic              card_pop,
  // AXI read
  output adma_pkg::addr_t   ar_addr,
  output adma_pkg::beats_t  ar_len,
  output logic [2:0]        ar_size,
  output logic [1:0]        ar_burst,
  output logic              ar_valid,
  input  logic              ar_ready,
  input  adma_pkg::word_t   r_data,
  input  logic              r_valid,
  input  logic              r_last,
  output logic              r_ready,
  // AXI write
  output adma_pkg::addr_t   aw_addr,
  output adma_pkg::beats_t  aw_len,
  output logic [2:0]        aw_size,
  output logic [1:0]        aw_burst,
  output logic              aw_valid,
  input  logic              aw_ready,
  output adma_pkg::word_t   w_data,
  output logic              w_valid,
  output logic              w_last,
  input  logic              w_ready
);

  logic              rd_start;
  adma_pkg::addr_t   rd_addr;
  adma_pkg::wcount_t rd_words;
  logic              rd_to_card;
  logic              rd_done;
  logic              wr_start;
  adma_pkg::addr_t   wr_addr;
  adma_pkg::wcount_t wr_words;
  logic              wr_done;
  adma_pkg::word_t   desc_word;
  logic              desc_word_valid;

  // 4-byte incrementing bursts only
  assign ar_size  = 3'b010;
  assign ar_burst = 2'b01;
  assign aw_size  = 3'b010;
  assign aw_burst = 2'b01;

  adma_sequencer u_sequencer (
    .clock           (clock),
    .reset           (reset),
    .dma_enable      (dma_enable),
    .cmd_done        (cmd_done),
    .data_present    (data_present),
    .dir_write       (dir_write),
    .blk_gap_req     (blk_gap_req),
    .irq_clear       (irq_clear),
    .desc_ptr_init   (desc_ptr_init),
    .desc_word       (desc_word),
    .desc_word_valid (desc_word_valid),
    .rd_done         (rd_done),
    .wr_done         (wr_done),
    .rd_start        (rd_start),
    .rd_addr         (rd_addr),
    .rd_words        (rd_words),
    .rd_to_card      (rd_to_card),
    .wr_start        (wr_start),
    .wr_addr         (wr_addr),
    .wr_words        (wr_words),
    .irq_complete    (irq_complete),
    .irq_error       (irq_error)
  );

  axi_read_engine #(
    .burst_beats (burst_beats)
  ) u_read_engine (
    .clock           (clock),
    .reset           (reset),
    .rd_start        (rd_start),
    .rd_addr         (rd_addr),
    .rd_words        (rd_words),
    .rd_to_card      (rd_to_card),
    .ar_addr         (ar_addr),
    .ar_len          (ar_len),
    .ar_valid        (ar_valid),
    .ar_ready        (ar_ready),
    .r_data          (r_data),
    .r_valid         (r_valid),
    .r_last          (r_last),
    .r_ready         (r_ready),
    .desc_word       (desc_word),
    .desc_word_valid (desc_word_valid),
    .card_wdata      (card_wdata),
    .card_wvalid     (card_wvalid),
    .rd_done         (rd_done)
  );

  axi_write_engine #(
    .burst_beats (burst_beats)
  ) u_write_engine (
    .clock      (clock),
    .reset      (reset),
    .wr_start   (wr_start),
    .wr_addr    (wr_addr),
    .wr_words   (wr_words),
    .card_push  (card_push),
    .card_rdata (card_rdata),
    .card_pop   (card_pop),
    .aw_addr    (aw_addr),
    .aw_len     (aw_len),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w_data     (w_data),
    .w_valid    (w_valid),
    .w_last     (w_last),
    .w_ready    (w_ready),
    .wr_done    (wr_done)
  );

endmodule

`default_nettype wire

// ==== hw/axi_write_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine #(
  parameter int unsigned burst_beats = 16
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               wr_start,
  input  adma_pkg::addr_t    wr_addr,
  input  adma_pkg::wcount_t  wr_words,
  input  logic               card_push,
  input  adma_pkg::word_t    card_rdata,
  output logic               card_pop,
  output adma_pkg::addr_t    aw_addr,
  output adma_pkg::beats_t   aw_len,
  output logic               aw_valid,
  input  logic               aw_ready,
  output adma_pkg::word_t    w_data,
  output logic               w_valid,
  output logic               w_last,
  input  logic               w_ready,
  output logic               wr_done
);

  adma_pkg::wcount_t fill;
  adma_pkg::wcount_t remaining;
  adma_pkg::wcount_t need;
  adma_pkg::beats_t  beat;
  adma_pkg::addr_t   next_addr;
  logic              active;
  logic              issue;
  logic              beat_ok;

  // Words the next burst needs in the card FIFO
  assign need  = adma_pkg::wcount_t'(adma_pkg::burst_len(remaining, burst_beats))
                 + adma_pkg::wcount_t'(1);
  assign issue = active && !aw_valid && !w_valid && (fill >= need);

  assign beat_ok  = w_valid && w_ready;
  assign w_last   = w_valid && (beat == aw_len);
  assign w_data   = card_rdata;
  assign card_pop = beat_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Card FIFO fill level
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      fill <= '0;
    end else begin
      fill <= fill + adma_pkg::wcount_t'(card_push) - adma_pkg::wcount_t'(card_pop);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data phases
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      active    <= 1'b0;
      remaining <= '0;
      aw_valid  <= 1'b0;
      aw_len    <= '0;
      w_valid   <= 1'b0;
      beat      <= '0;
      wr_done   <= 1'b0;
    end else begin
      wr_done <= 1'b0;

      if (wr_start) begin
        active    <= 1'b1;
        remaining <= wr_words;
      end

      if (issue) begin
        aw_valid <= 1'b1;
        aw_len   <= adma_pkg::burst_len(remaining, burst_beats);
      end

      if (aw_valid && aw_ready) begin
        aw_valid <= 1'b0;
        w_valid  <= 1'b1;
        beat     <= '0;
      end

      if (beat_ok) begin
        remaining <= remaining - adma_pkg::wcount_t'(1);
        beat      <= beat + adma_pkg::beats_t'(1);
        if (w_last) begin
          w_valid <= 1'b0;
          // Last beat of the last burst
          if (remaining == adma_pkg::wcount_t'(1)) begin
            active  <= 1'b0;
            wr_done <= 1'b1;
          end
        end
      end
    end
  end

  // Burst addresses step by the size of the burst just issued
  always_ff @(posedge clock) begin
    if (wr_start) begin
      next_addr <= wr_addr;
    end else if (issue) begin
      aw_addr   <= next_addr;
      next_addr <= next_addr
                   + adma_pkg::addr_t'(need) * adma_pkg::addr_t'(adma_pkg::word_bytes);
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine #(
  parameter int unsigned burst_beats = 16
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               rd_start,
  input  adma_pkg::addr_t    rd_addr,
  input  adma_pkg::wcount_t  rd_words,
  input  logic               rd_to_card,
  output adma_pkg::addr_t    ar_addr,
  output adma_pkg::beats_t   ar_len,
  output logic               ar_valid,
  input  logic               ar_ready,
  input  adma_pkg::word_t    r_data,
  input  logic               r_valid,
  input  logic               r_last,
  output logic               r_ready,
  output adma_pkg::word_t    desc_word,
  output logic               desc_word_valid,
  output adma_pkg::word_t    card_wdata,
  output logic               card_wvalid,
  output logic               rd_done
);

  adma_pkg::wcount_t remaining;
  adma_pkg::wcount_t words_left;
  adma_pkg::addr_t   burst_bytes;
  logic              beat_ok;

  assign beat_ok     = r_valid && r_ready;
  assign words_left  = remaining - adma_pkg::wcount_t'(1);
  assign burst_bytes = (adma_pkg::addr_t'(ar_len) + adma_pkg::addr_t'(1))
                       * adma_pkg::addr_t'(adma_pkg::word_bytes);

  // Beats go to the descriptor line or to the card FIFO
  assign desc_word       = r_data;
  assign desc_word_valid = beat_ok && !rd_to_card;
  assign card_wdata      = r_data;
  assign card_wvalid     = beat_ok && rd_to_card;

  ////////////////////////////////////////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      ar_valid  <= 1'b0;
      ar_len    <= '0;
      r_ready   <= 1'b0;
      remaining <= '0;
      rd_done   <= 1'b0;
    end else begin
      rd_done <= 1'b0;

      if (rd_start) begin
        ar_valid  <= 1'b1;
        ar_len    <= adma_pkg::burst_len(rd_words, burst_beats);
        remaining <= rd_words;
      end else if (ar_valid && ar_ready) begin
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
      end

      if (beat_ok) begin
        remaining <= words_left;
        if (r_last) begin
          r_ready <= 1'b0;
          // Either the whole transfer is in or another burst follows
          if (words_left == '0) begin
            rd_done <= 1'b1;
          end else begin
            ar_valid <= 1'b1;
            ar_len   <= adma_pkg::burst_len(words_left, burst_beats);
          end
        end
      end
    end
  end

  // Address of the next burst
  always_ff @(posedge clock) begin
    if (rd_start) begin
      ar_addr <= rd_addr;
    end else if (beat_ok && r_last) begin
      ar_addr <= ar_addr + burst_bytes;
    end
  end

endmodule

`default_nettype wire

// ==== hw/adma_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module adma_sequencer (
  input  logic               clock,
  input  logic               reset,
  input  logic               dma_enable,
  input  logic               cmd_done,
  input  logic               data_present,
  input  logic               dir_write,
  input  logic               blk_gap_req,
  input  logic               irq_clear,
  input  adma_pkg::addr_t    desc_ptr_init,
  input  adma_pkg::word_t    desc_word,
  input  logic               desc_word_valid,
  input  logic               rd_done,
  input  logic               wr_done,
  output logic               rd_start,
  output adma_pkg::addr_t    rd_addr,
  output adma_pkg::wcount_t  rd_words,
  output logic               rd_to_card,
  output logic               wr_start,
  output adma_pkg::addr_t    wr_addr,
  output adma_pkg::wcount_t  wr_words,
  output logic               irq_complete,
  output logic               irq_error
);

  adma_pkg::adma_state_t state;
  adma_pkg::addr_t       desc_ptr;
  adma_pkg::desc_t       desc;
  logic                  desc_half;

  logic                  desc_valid;
  logic                  desc_end;
  logic [1:0]            desc_act;
  logic                  desc_nop;
  adma_pkg::addr_t       desc_addr;
  logic [15:0]           desc_len;
  logic [16:0]           desc_bytes;
  adma_pkg::wcount_t     desc_len_words;

  logic                  xfer_done;
  logic                  fetch_go;
  adma_pkg::addr_t       fetch_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor fields
  ////////////////////////////////////////////////////////////////////////////

  assign desc_valid = desc[adma_pkg::desc_valid_bit];
  assign desc_end   = desc[adma_pkg::desc_end_bit];
  assign desc_act   = desc[adma_pkg::desc_act_lsb +: 2];
  assign desc_nop   = (desc_act != adma_pkg::act_tran) && (desc_act != adma_pkg::act_link);
  assign desc_addr  = desc[adma_pkg::desc_addr_lsb +: 32];
  assign desc_len   = desc[adma_pkg::desc_len_lsb +: 16];

  // Zero length encodes 65536 bytes
  assign desc_bytes     = (desc_len == 16'h0000) ? 17'h10000 : {1'b0, desc_len};
  assign desc_len_words = adma_pkg::wcount_t'(desc_bytes / adma_pkg::word_bytes);

  assign xfer_done = rd_done || wr_done;

  // Next descriptor fetch and where it reads from
  always_comb begin
    fetch_go   = 1'b0;
    fetch_addr = desc_ptr + adma_pkg::addr_t'(adma_pkg::desc_step);
    case (state)
      adma_pkg::ST_STOP: begin
        if (dma_enable && cmd_done && data_present) begin
          fetch_go   = 1'b1;
          fetch_addr = desc_ptr_init;
        end
      end
      adma_pkg::ST_DECODE: begin
        if (desc_valid && desc_act == adma_pkg::act_link) begin
          fetch_go   = 1'b1;
          fetch_addr = desc_addr;
        end else if (desc_valid && desc_nop && !desc_end) begin
          fetch_go = 1'b1;
        end
      end
      adma_pkg::ST_XFER: begin
        fetch_go = xfer_done && !desc_end && !blk_gap_req;
      end
      default: begin
        fetch_go = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State machine and interrupts
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state        <= adma_pkg::ST_STOP;
      rd_start     <= 1'b0;
      wr_start     <= 1'b0;
      desc_half    <= 1'b0;
      irq_complete <= 1'b0;
      irq_error    <= 1'b0;
    end else begin
      rd_start <= fetch_go;
      wr_start <= 1'b0;

      // Low word arrives first
      if (fetch_go) begin
        desc_half <= 1'b0;
      end else if (desc_word_valid) begin
        desc_half <= !desc_half;
      end

      if (irq_clear) begin
        irq_complete <= 1'b0;
        irq_error    <= 1'b0;
      end

      case (state)
        adma_pkg::ST_STOP: begin
          if (fetch_go) begin
            state <= adma_pkg::ST_FETCH;
          end
        end
        adma_pkg::ST_FETCH: begin
          if (rd_done) begin
            state <= adma_pkg::ST_DECODE;
          end
        end
        adma_pkg::ST_DECODE: begin
          if (!desc_valid) begin
            irq_error <= 1'b1;
            state     <= adma_pkg::ST_STOP;
          end else if (desc_act == adma_pkg::act_tran) begin
            rd_start <= !dir_write;
            wr_start <= dir_write;
            state    <= adma_pkg::ST_XFER;
          end else if (fetch_go) begin
            state <= adma_pkg::ST_FETCH;
          end else begin
            // Nop with end
            irq_complete <= 1'b1;
            state        <= adma_pkg::ST_STOP;
          end
        end
        adma_pkg::ST_XFER: begin
          if (fetch_go) begin
            state <= adma_pkg::ST_FETCH;
          end else if (xfer_done) begin
            irq_complete <= 1'b1;
            state        <= adma_pkg::ST_STOP;
          end
        end
        default: begin
          state <= adma_pkg::ST_STOP;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer, descriptor line and engine requests
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (desc_word_valid) begin
      if (!desc_half) begin
        desc[31:0] <= desc_word;
      end else begin
        desc[63:32] <= desc_word;
      end
    end

    if (fetch_go) begin
      desc_ptr   <= fetch_addr;
      rd_addr    <= fetch_addr;
      rd_words   <= adma_pkg::wcount_t'(adma_pkg::desc_words);
      rd_to_card <= 1'b0;
    end else if (state == adma_pkg::ST_DECODE && desc_valid) begin
      if (desc_act == adma_pkg::act_tran) begin
        rd_addr    <= desc_addr;
        rd_words   <= desc_len_words;
        rd_to_card <= 1'b1;
        wr_addr    <= desc_addr;
        wr_words   <= desc_len_words;
      end else begin
        desc_ptr <= desc_ptr + adma_pkg::addr_t'(adma_pkg::desc_step);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/adma_pkg.sv ====
`default_nettype none

package adma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] desc_t;

  // Up to 16384 words, a 64 KiB descriptor
  typedef logic [14:0] wcount_t;

  // AXI len field, beats minus one
  typedef logic [7:0]  beats_t;

  typedef enum logic [1:0] {
    ST_STOP,
    ST_FETCH,
    ST_DECODE,
    ST_XFER
  } adma_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // ADMA2 descriptor layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned desc_valid_bit = 0;
  localparam int unsigned desc_end_bit   = 1;
  localparam int unsigned desc_act_lsb   = 4;
  localparam int unsigned desc_len_lsb   = 16;
  localparam int unsigned desc_addr_lsb  = 32;

  // Nop is 00 or 01
  localparam logic [1:0] act_tran = 2'b10;
  localparam logic [1:0] act_link = 2'b11;

  localparam int unsigned desc_words = 2;
  localparam int unsigned desc_step  = 8;
  localparam int unsigned word_bytes = 4;

  // Beats of the next burst, minus one, for a given number of words left
  function automatic beats_t burst_len(wcount_t words, int unsigned max_beats);
    if (words >= wcount_t'(max_beats)) begin
      return beats_t'(max_beats - 1);
    end
    return beats_t'(words - wcount_t'(1));
  endfunction

endpackage

`default_nettype wire
